/* mem_bus_pkg.sv */
package mem_bus_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// channel payloads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} r32_t;

	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
	} r64_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} aw_t;

	typedef struct packed {
		logic [63:0] data;
		logic [7:0]  strb;
	} w_t;

	typedef struct packed {
		logic [1:0] resp;
	} b_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address map and sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
	localparam logic [31:0] CLINT_LAST = 32'h0200_ffff;
	localparam logic [31:0] MTIME_LO   = 32'h0200_bff8;
	localparam logic [31:0] MTIME_HI   = 32'h0200_bffc;

	localparam int MEM_WORDS = 1024;         // 64-bit words, 8 KiB
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);

	localparam logic [1:0] RESP_OKAY = 2'd0;
	localparam logic [2:0] IFU_SIZE  = 3'd2; // fetch is always one word

	// true for any address inside the clint window
	function automatic logic in_clint(logic [31:0] addr);
		return (addr >= CLINT_BASE) && (addr <= CLINT_LAST);
	endfunction

endpackage

/* resp_slot.sv */
module resp_slot #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     load,
	input  payload_t din,
	input  logic     ready,
	output logic     valid,
	output payload_t dout,
	output logic     empty
);

	logic valid_nxt;

	always_comb begin
		valid_nxt = valid;
		if (load)
			valid_nxt = 1'b1;
		else if (ready)
			valid_nxt = 1'b0;
	end

	// empty is kept as its own flop so it stays low while in reset
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid <= 1'b0;
			empty <= 1'b0;
		end else begin
			valid <= valid_nxt;
			empty <= ~valid_nxt;
		end
	end

	always_ff @(posedge clock) begin
		if (load)
			dout <= din;
	end

	a_no_load_when_full: assert property (@(posedge clock) disable iff (!rst_n)
		load |-> empty);

	a_hold_until_taken: assert property (@(posedge clock) disable iff (!rst_n)
		valid && !ready |=> valid && $stable(dout));

endmodule

/* sram_slave.sv */
module sram_slave (
	input  logic               clock,
	input  logic               rst_n,

	input  mem_bus_pkg::ar_t   ar,
	input  logic               arvalid,
	output logic               arready,

	output mem_bus_pkg::r64_t  r,
	output logic               rvalid,
	input  logic               rready,

	input  mem_bus_pkg::aw_t   aw,
	input  logic               awvalid,
	output logic               awready,

	input  mem_bus_pkg::w_t    w,
	input  logic               wvalid,
	output logic               wready,

	output mem_bus_pkg::b_t    b,
	output logic               bvalid,
	input  logic               bready
);

	import mem_bus_pkg::*;

	logic [63:0] mem [MEM_WORDS];

	logic [MEM_IDX_W-1:0] rd_idx;
	logic [MEM_IDX_W-1:0] wr_idx;
	logic                 r_empty;
	logic                 b_empty;
	logic                 ar_fire;
	logic                 wr_fire;
	r64_t                 rd_beat;
	b_t                   wr_resp;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign rd_idx  = ar.addr[3 +: MEM_IDX_W]; // wraps past 8 KiB
	assign arready = r_empty;
	assign ar_fire = arvalid & arready;

	always_comb begin
		rd_beat.data = mem[rd_idx];
		rd_beat.resp = RESP_OKAY;
	end

	resp_slot #(
		.payload_t(r64_t)
	) u_r_slot (
		.clock(clock),
		.rst_n(rst_n),
		.load (ar_fire),
		.din  (rd_beat),
		.ready(rready),
		.valid(rvalid),
		.dout (r),
		.empty(r_empty)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// aw and w only ever go in together
	assign wr_fire      = awvalid & wvalid & b_empty;
	assign awready      = wr_fire;
	assign wready       = wr_fire;
	assign wr_idx       = aw.addr[3 +: MEM_IDX_W];
	assign wr_resp.resp = RESP_OKAY;

	always_ff @(posedge clock) begin
		if (wr_fire) begin
			for (int i = 0; i < 8; i++) begin
				if (w.strb[i])
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
	end

	resp_slot #(
		.payload_t(b_t)
	) u_b_slot (
		.clock(clock),
		.rst_n(rst_n),
		.load (wr_fire),
		.din  (wr_resp),
		.ready(bready),
		.valid(bvalid),
		.dout (b),
		.empty(b_empty)
	);

	a_aw_w_paired: assert property (@(posedge clock) disable iff (!rst_n)
		awready == wready);

endmodule

/* clint.sv */
module clint (
	input  logic              clock,
	input  logic              rst_n,

	input  mem_bus_pkg::ar_t  ar,
	input  logic              arvalid,
	output logic              arready,

	output mem_bus_pkg::r32_t r,
	output logic              rvalid,
	input  logic              rready
);

	import mem_bus_pkg::*;

	logic [63:0] mtime;
	logic        r_empty;
	logic        ar_fire;
	r32_t        rd_word;

	// free running, no compare or interrupt
	always_ff @(posedge clock) begin
		if (!rst_n)
			mtime <= '0;
		else
			mtime <= mtime + 64'd1;
	end

	assign arready = r_empty;
	assign ar_fire = arvalid & arready;

	always_comb begin
		rd_word.resp = RESP_OKAY;
		case (ar.addr)
			MTIME_LO: rd_word.data = mtime[31:0];
			MTIME_HI: rd_word.data = mtime[63:32];
			default:  rd_word.data = '0; // rest of the window reads zero
		endcase
	end

	resp_slot #(
		.payload_t(r32_t)
	) u_r_slot (
		.clock(clock),
		.rst_n(rst_n),
		.load (ar_fire),
		.din  (rd_word),
		.ready(rready),
		.valid(rvalid),
		.dout (r),
		.empty(r_empty)
	);

	// decode upstream must keep other traffic away
	a_addr_in_window: assert property (@(posedge clock) disable iff (!rst_n)
		arvalid |-> in_clint(ar.addr));

endmodule

/* mem_xbar.sv */
module mem_xbar (
	input  logic              clock,
	input  logic              rst_n,

	input  mem_bus_pkg::ar_t  ifu_ar,
	input  logic              ifu_arvalid,
	output logic              ifu_arready,
	output mem_bus_pkg::r32_t ifu_r,
	output logic              ifu_rvalid,
	input  logic              ifu_rready,

	input  mem_bus_pkg::ar_t  lsu_ar,
	input  logic              lsu_arvalid,
	output logic              lsu_arready,
	output mem_bus_pkg::r32_t lsu_r,
	output logic              lsu_rvalid,
	input  logic              lsu_rready,
	input  mem_bus_pkg::aw_t  lsu_aw,
	input  logic              lsu_awvalid,
	output logic              lsu_awready,
	input  logic [31:0]       lsu_wdata,
	input  logic [7:0]        lsu_wstrb,
	input  logic              lsu_wvalid,
	output logic              lsu_wready,
	output mem_bus_pkg::b_t   lsu_b,
	output logic              lsu_bvalid,
	input  logic              lsu_bready,

	output mem_bus_pkg::ar_t  sram_ar,
	output logic              sram_arvalid,
	input  logic              sram_arready,
	input  mem_bus_pkg::r64_t sram_r,
	input  logic              sram_rvalid,
	output logic              sram_rready,
	output mem_bus_pkg::aw_t  sram_aw,
	output logic              sram_awvalid,
	input  logic              sram_awready,
	output mem_bus_pkg::w_t   sram_w,
	output logic              sram_wvalid,
	input  logic              sram_wready,
	input  mem_bus_pkg::b_t   sram_b,
	input  logic              sram_bvalid,
	output logic              sram_bready,

	output mem_bus_pkg::ar_t  clint_ar,
	output logic              clint_arvalid,
	input  logic              clint_arready,
	input  mem_bus_pkg::r32_t clint_r,
	input  logic              clint_rvalid,
	output logic              clint_rready
);

	import mem_bus_pkg::*;

	typedef enum logic [1:0] {
		GNT_IDLE,
		GNT_IFU,
		GNT_LSU
	} gnt_t;

	gnt_t gnt_q;
	logic sel_clint_q;  // outstanding lsu read went to the clint
	logic half_q;       // addr[2] of the outstanding read
	logic idle;
	logic req_ifu;
	logic req_lsu;
	logic lsu_to_clint;
	logic ar_fire;
	logic r_fire;
	r32_t sram_half;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read request, ifu first
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign idle         = (gnt_q == GNT_IDLE);
	assign req_ifu      = idle & ifu_arvalid;
	assign req_lsu      = idle & ~ifu_arvalid & lsu_arvalid;
	assign lsu_to_clint = in_clint(lsu_ar.addr);

	assign sram_arvalid  = req_ifu | (req_lsu & ~lsu_to_clint);
	assign sram_ar       = req_ifu ? ar_t'{addr: ifu_ar.addr, size: IFU_SIZE} : lsu_ar;
	assign clint_arvalid = req_lsu & lsu_to_clint;
	assign clint_ar      = lsu_ar;

	assign ifu_arready = req_ifu & sram_arready;
	assign lsu_arready = req_lsu & (lsu_to_clint ? clint_arready : sram_arready);

	assign ar_fire = ifu_arready | lsu_arready;
	assign r_fire  = (ifu_rvalid & ifu_rready) | (lsu_rvalid & lsu_rready);

	always_ff @(posedge clock) begin
		if (!rst_n)
			gnt_q <= GNT_IDLE;
		else if (ar_fire)
			gnt_q <= req_ifu ? GNT_IFU : GNT_LSU;
		else if (r_fire)
			gnt_q <= GNT_IDLE;
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			sel_clint_q <= clint_arvalid;
			half_q      <= req_ifu ? ifu_ar.addr[2] : lsu_ar.addr[2];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read response
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign sram_half.data = half_q ? sram_r.data[63:32] : sram_r.data[31:0];
	assign sram_half.resp = sram_r.resp;

	assign ifu_rvalid = (gnt_q == GNT_IFU) & sram_rvalid;
	assign lsu_rvalid = (gnt_q == GNT_LSU) & (sel_clint_q ? clint_rvalid : sram_rvalid);
	assign ifu_r      = sram_half;
	assign lsu_r      = sel_clint_q ? clint_r : sram_half;

	assign sram_rready  = ((gnt_q == GNT_IFU) & ifu_rready) |
	                      ((gnt_q == GNT_LSU) & ~sel_clint_q & lsu_rready);
	assign clint_rready = (gnt_q == GNT_LSU) & sel_clint_q & lsu_rready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// writes, straight to sram
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign sram_aw      = lsu_aw;
	assign sram_awvalid = lsu_awvalid;
	assign lsu_awready  = sram_awready;

	assign sram_w.data = {2{lsu_wdata}}; // strobe picks the half
	assign sram_w.strb = lsu_wstrb;
	assign sram_wvalid = lsu_wvalid;
	assign lsu_wready  = sram_wready;

	assign lsu_b       = sram_b;
	assign lsu_bvalid  = sram_bvalid;
	assign sram_bready = lsu_bready;

	a_one_master: assert property (@(posedge clock) disable iff (!rst_n)
		!((ifu_arready || ifu_rvalid) && (lsu_arready || lsu_rvalid)));

endmodule

/* mem_subsys.sv */
module mem_subsys (
	input  logic              clock,
	input  logic              rst_n,

	input  mem_bus_pkg::ar_t  ifu_ar,
	input  logic              ifu_arvalid,
	output logic              ifu_arready,
	output mem_bus_pkg::r32_t ifu_r,
	output logic              ifu_rvalid,
	input  logic              ifu_rready,

	input  mem_bus_pkg::ar_t  lsu_ar,
	input  logic              lsu_arvalid,
	output logic              lsu_arready,
	output mem_bus_pkg::r32_t lsu_r,
	output logic              lsu_rvalid,
	input  logic              lsu_rready,
	input  mem_bus_pkg::aw_t  lsu_aw,
	input  logic              lsu_awvalid,
	output logic              lsu_awready,
	input  logic [31:0]       lsu_wdata,
	input  logic [7:0]        lsu_wstrb,
	input  logic              lsu_wvalid,
	output logic              lsu_wready,
	output mem_bus_pkg::b_t   lsu_b,
	output logic              lsu_bvalid,
	input  logic              lsu_bready
);

	import mem_bus_pkg::*;

	// crossbar to sram
	ar_t  sram_ar;
	logic sram_arvalid;
	logic sram_arready;
	r64_t sram_r;
	logic sram_rvalid;
	logic sram_rready;
	aw_t  sram_aw;
	logic sram_awvalid;
	logic sram_awready;
	w_t   sram_w;
	logic sram_wvalid;
	logic sram_wready;
	b_t   sram_b;
	logic sram_bvalid;
	logic sram_bready;

	// crossbar to clint
	ar_t  clint_ar;
	logic clint_arvalid;
	logic clint_arready;
	r32_t clint_r;
	logic clint_rvalid;
	logic clint_rready;

	mem_xbar u_xbar (.*);

	sram_slave u_sram (
		.clock  (clock),
		.rst_n  (rst_n),
		.ar     (sram_ar),
		.arvalid(sram_arvalid),
		.arready(sram_arready),
		.r      (sram_r),
		.rvalid (sram_rvalid),
		.rready (sram_rready),
		.aw     (sram_aw),
		.awvalid(sram_awvalid),
		.awready(sram_awready),
		.w      (sram_w),
		.wvalid (sram_wvalid),
		.wready (sram_wready),
		.b      (sram_b),
		.bvalid (sram_bvalid),
		.bready (sram_bready)
	);

	clint u_clint (
		.clock  (clock),
		.rst_n  (rst_n),
		.ar     (clint_ar),
		.arvalid(clint_arvalid),
		.arready(clint_arready),
		.r      (clint_r),
		.rvalid (clint_rvalid),
		.rready (clint_rready)
	);

endmodule

/* tb_mem_subsys.sv */
module tb_mem_subsys;

	import mem_bus_pkg::*;

	localparam int PERIOD = 100;
	localparam int SAMPLE = 25; // after the falling edge, well before the rising one

	typedef enum {OP_WRITE, OP_READ, OP_DUAL, OP_MTIME} op_kind_t;

	typedef struct {
		string       name;
		op_kind_t    kind;
		bit          lsu;   // master, 0 is ifu
		logic [31:0] addr;
		logic [31:0] addr2; // lsu address of a dual read
		logic [31:0] data;
		logic [7:0]  strb;
		int          stall;
		logic [31:0] exp;
		logic [31:0] exp2;
	} op_t;

	logic        clock = 1'b0;
	logic        rst_n;
	ar_t         ifu_ar;
	logic        ifu_arvalid;
	logic        ifu_arready;
	r32_t        ifu_r;
	logic        ifu_rvalid;
	logic        ifu_rready;
	ar_t         lsu_ar;
	logic        lsu_arvalid;
	logic        lsu_arready;
	r32_t        lsu_r;
	logic        lsu_rvalid;
	logic        lsu_rready;
	aw_t         lsu_aw;
	logic        lsu_awvalid;
	logic        lsu_awready;
	logic [31:0] lsu_wdata;
	logic [7:0]  lsu_wstrb;
	logic        lsu_wvalid;
	logic        lsu_wready;
	b_t          lsu_b;
	logic        lsu_bvalid;
	logic        lsu_bready;

	op_t         ops[$];
	logic [63:0] ref_mem [logic [9:0]];
	logic [31:0] lcg_state = 32'h6150;
	int          errors = 0;
	int          cycles = 0;
	int          cycle_limit = 1000;

	mem_subsys dut0 (.*);

	always #(PERIOD / 2) clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: no progress after %0d cycles", cycle_limit);
			$display("errors: %0d", errors);
			$display("sim failed");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	function automatic logic [31:0] ref_read(logic [31:0] addr);
		logic [63:0] word;
		if (addr[31:16] == 16'h0200)
			return 32'h0; // clint, mtime_lo is checked by ordering only
		word = ref_mem[addr[12:3]];
		return addr[2] ? word[63:32] : word[31:0];
	endfunction

	function automatic void ref_write(logic [31:0] addr, logic [31:0] data, logic [7:0] strb);
		logic [63:0] word;
		logic [63:0] wide;
		wide = {data, data};
		word = ref_mem.exists(addr[12:3]) ? ref_mem[addr[12:3]] : 64'hx;
		for (int i = 0; i < 8; i++) begin
			if (strb[i])
				word[8*i +: 8] = wide[8*i +: 8];
		end
		ref_mem[addr[12:3]] = word;
	endfunction

	function automatic logic arready_of(bit lsu);
		return lsu ? lsu_arready : ifu_arready;
	endfunction

	function automatic logic rvalid_of(bit lsu);
		return lsu ? lsu_rvalid : ifu_rvalid;
	endfunction

	function automatic logic [31:0] rdata_of(bit lsu);
		return lsu ? lsu_r.data : ifu_r.data;
	endfunction

	function automatic logic [1:0] rresp_of(bit lsu);
		return lsu ? lsu_r.resp : ifu_r.resp;
	endfunction

	task automatic set_ar(input bit lsu, input logic v, input logic [31:0] addr);
		if (lsu) begin
			lsu_arvalid = v;
			lsu_ar.addr = addr;
			lsu_ar.size = 3'd2;
		end else begin
			ifu_arvalid = v;
			ifu_ar.addr = addr;
			ifu_ar.size = 3'd2;
		end
	endtask

	task automatic set_rready(input bit lsu, input logic v);
		if (lsu)
			lsu_rready = v;
		else
			ifu_rready = v;
	endtask

	task automatic check_quiet(input string tag);
		compare({tag, " ifu_arready"}, 64'(0), 64'(ifu_arready));
		compare({tag, " ifu_rvalid"}, 64'(0), 64'(ifu_rvalid));
		compare({tag, " lsu_arready"}, 64'(0), 64'(lsu_arready));
		compare({tag, " lsu_rvalid"}, 64'(0), 64'(lsu_rvalid));
		compare({tag, " lsu_awready"}, 64'(0), 64'(lsu_awready));
		compare({tag, " lsu_wready"}, 64'(0), 64'(lsu_wready));
		compare({tag, " lsu_bvalid"}, 64'(0), 64'(lsu_bvalid));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operation table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic add_op(input string name, input op_kind_t kind, input bit lsu,
		input logic [31:0] addr, input logic [31:0] addr2, input logic [7:0] strb,
		input int stall);
		op_t op;
		op.name  = name;
		op.kind  = kind;
		op.lsu   = lsu;
		op.addr  = addr;
		op.addr2 = addr2;
		op.data  = lcg_next();
		op.strb  = strb;
		op.stall = stall;
		if (kind == OP_WRITE)
			ref_write(addr, op.data, strb);
		op.exp  = ref_read(addr);
		op.exp2 = ref_read(addr2);
		ops.push_back(op);
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		add_op("init_a", OP_WRITE, 1'b1, 32'h100, 32'h0, 8'hff, 0);
		add_op("init_b", OP_WRITE, 1'b1, 32'h108, 32'h0, 8'hff, 0);
		rnd = lcg_next();
		add_op("strb_a", OP_WRITE, 1'b1, 32'h100, 32'h0, rnd[7:0] | 8'h11, 0);
		rnd = lcg_next();
		add_op("strb_b", OP_WRITE, 1'b1, 32'h108, 32'h0, rnd[7:0] | 8'h11, 0);
		add_op("lsu_rd_a_lo", OP_READ, 1'b1, 32'h100, 32'h0, 8'h0, 0);
		add_op("lsu_rd_a_hi", OP_READ, 1'b1, 32'h104, 32'h0, 8'h0, 0);
		add_op("ifu_rd_a_lo", OP_READ, 1'b0, 32'h100, 32'h0, 8'h0, 0);
		add_op("ifu_rd_a_hi", OP_READ, 1'b0, 32'h104, 32'h0, 8'h0, 0);
		add_op("dual_rd", OP_DUAL, 1'b0, 32'h104, 32'h210c, 8'h0, 0); // lsu side wraps
		add_op("mtime_0", OP_MTIME, 1'b1, MTIME_LO, 32'h0, 8'h0, 0);
		rnd = lcg_next();
		add_op("mtime_1", OP_MTIME, 1'b1, MTIME_LO, 32'h0, 8'h0, int'(rnd % 32'd5) + 1);
		add_op("mtime_hi", OP_READ, 1'b1, MTIME_HI, 32'h0, 8'h0, 0);
		add_op("clint_other", OP_READ, 1'b1, 32'h0200_4000, 32'h0, 8'h0, 0);
		rnd = lcg_next();
		add_op("stall_lsu", OP_READ, 1'b1, 32'h10c, 32'h0, 8'h0, int'(rnd % 32'd6) + 2);
		rnd = lcg_next();
		add_op("stall_ifu", OP_READ, 1'b0, 32'h108, 32'h0, 8'h0, int'(rnd % 32'd4) + 1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus tasks, entered on a falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic wait_ar(input bit lsu);
		#SAMPLE;
		while (!arready_of(lsu)) begin
			@(negedge clock);
			#SAMPLE;
		end
	endtask

	// ends on the sample just before the r handshake edge
	task automatic collect_r(input string name, input bit lsu, input int stall,
		output logic [31:0] got);
		logic [31:0] held;
		set_rready(lsu, stall == 0);
		#SAMPLE;
		compare({name, " rvalid latency"}, 64'(1), 64'(rvalid_of(lsu)));
		held = rdata_of(lsu);
		for (int i = 0; i < stall; i++) begin
			@(negedge clock);
			if (i == stall - 1)
				set_rready(lsu, 1'b1);
			#SAMPLE;
			compare({name, " rvalid held"}, 64'(1), 64'(rvalid_of(lsu)));
			compare({name, " rdata held"}, 64'(held), 64'(rdata_of(lsu)));
		end
		compare({name, " resp"}, 64'(RESP_OKAY), 64'(rresp_of(lsu)));
		got = rdata_of(lsu);
	endtask

	task automatic do_read(input string name, input bit lsu, input logic [31:0] addr,
		input int stall, output logic [31:0] got);
		set_ar(lsu, 1'b1, addr);
		wait_ar(lsu);
		compare({name, " rvalid early"}, 64'(0), 64'(rvalid_of(lsu)));
		@(negedge clock);
		set_ar(lsu, 1'b0, addr);
		collect_r(name, lsu, stall, got);
		@(negedge clock);
		set_rready(lsu, 1'b0);
	endtask

	task automatic do_write(input op_t op);
		lsu_aw.addr = op.addr;
		lsu_aw.size = 3'd3;
		lsu_wdata   = op.data;
		lsu_wstrb   = op.strb;
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		#SAMPLE;
		while (!lsu_awready) begin
			@(negedge clock);
			#SAMPLE;
		end
		compare({op.name, " wready"}, 64'(1), 64'(lsu_wready));
		compare({op.name, " bvalid early"}, 64'(0), 64'(lsu_bvalid));
		@(negedge clock);
		lsu_awvalid = 1'b0;
		lsu_wvalid  = 1'b0;
		lsu_bready  = 1'b1;
		#SAMPLE;
		compare({op.name, " bvalid latency"}, 64'(1), 64'(lsu_bvalid));
		compare({op.name, " bresp"}, 64'(RESP_OKAY), 64'(lsu_b.resp));
		@(negedge clock);
		lsu_bready = 1'b0;
	endtask

	task automatic do_dual(input op_t op);
		logic [31:0] got;
		set_ar(1'b0, 1'b1, op.addr);
		set_ar(1'b1, 1'b1, op.addr2);
		wait_ar(1'b0);
		compare({op.name, " lsu held off"}, 64'(0), 64'(lsu_arready));
		@(negedge clock);
		set_ar(1'b0, 1'b0, op.addr);
		collect_r({op.name, " ifu"}, 1'b0, 0, got);
		compare({op.name, " lsu waits for ifu r"}, 64'(0), 64'(lsu_arready));
		compare({op.name, " ifu data"}, 64'(op.exp), 64'(got));
		@(negedge clock);
		set_rready(1'b0, 1'b0);
		wait_ar(1'b1);
		@(negedge clock);
		set_ar(1'b1, 1'b0, op.addr2);
		collect_r({op.name, " lsu"}, 1'b1, 0, got);
		compare({op.name, " lsu data"}, 64'(op.exp2), 64'(got));
		@(negedge clock);
		set_rready(1'b1, 1'b0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic [31:0] got;
		logic [31:0] mtime_prev;
		logic        mtime_seen;
		rst_n       = 1'b0;
		ifu_ar      = '0;
		ifu_arvalid = 1'b0;
		ifu_rready  = 1'b0;
		lsu_ar      = '0;
		lsu_arvalid = 1'b0;
		lsu_rready  = 1'b0;
		lsu_aw      = '0;
		lsu_awvalid = 1'b0;
		lsu_wdata   = '0;
		lsu_wstrb   = '0;
		lsu_wvalid  = 1'b0;
		lsu_bready  = 1'b0;
		mtime_seen  = 1'b0;
		mtime_prev  = '0;
		build_table();
		cycle_limit = ops.size() * 20;

		repeat (2) @(negedge clock);
		check_quiet("in reset");
		compare("in reset sram arready", 64'(0), 64'(dut0.sram_arready));
		rst_n = 1'b1;
		#SAMPLE;
		check_quiet("after reset");
		@(negedge clock);
		#SAMPLE;
		check_quiet("idle");
		compare("sram arready up", 64'(1), 64'(dut0.sram_arready));
		compare("clint arready up", 64'(1), 64'(dut0.clint_arready));
		@(negedge clock);

		foreach (ops[i]) begin
			case (ops[i].kind)
				OP_WRITE: do_write(ops[i]);
				OP_READ: begin
					do_read(ops[i].name, ops[i].lsu, ops[i].addr, ops[i].stall, got);
					compare(ops[i].name, 64'(ops[i].exp), 64'(got));
				end
				OP_DUAL: do_dual(ops[i]);
				default: begin
					do_read(ops[i].name, ops[i].lsu, ops[i].addr, ops[i].stall, got);
					if (mtime_seen && got <= mtime_prev) begin
						errors++;
						$display("%s: mtime did not increase, read %0d after %0d",
							ops[i].name, got, mtime_prev);
					end
					mtime_seen = 1'b1;
					mtime_prev = got;
				end
			endcase
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* mem_subsys.f */
mem_bus_pkg.sv
resp_slot.sv
sram_slave.sv
clint.sv
mem_xbar.sv
mem_subsys.sv
tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_mem_subsys \
	-f mem_subsys.f -o sim_mem_subsys; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_mem_subsys)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
